// ==== common/icache_pkg.sv ====
package icache_pkg;

    localparam int ADDR_WIDTH       = 32;
    localparam int LINE_WIDTH       = 128;
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int TAG_WIDTH        = ADDR_WIDTH - PAGE_OFFSET_BITS;
    localparam int WB_DATA_WIDTH    = 32;

    // TLB answer for the request in lookup
    typedef struct packed {
        logic                 found;
        logic [TAG_WIDTH-1:0] ppn;
    } tlb_result_t;

    // Translation request from the fetch unit
    typedef struct packed {
        logic                 trans_en;
        logic [TAG_WIDTH-1:0] vpn;
    } tlb_req_t;

    // Line refill from cache to bridge
    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] addr;
    } refill_req_t;

    // Line refill from bridge to cache
    typedef struct packed {
        logic                  rdy;
        logic                  rvalid;
        logic [LINE_WIDTH-1:0] data;
    } refill_resp_t;

    // Wishbone classic from master to slave
    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic                         we;
        logic [ADDR_WIDTH-1:0]        adr;
        logic [WB_DATA_WIDTH/8-1:0]   sel;
    } wb_m2s_t;

    // Wishbone classic from slave to master
    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_s2m_t;

endpackage

// ==== hdl/dp_bram.sv ====
module dp_bram #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 64
) (
    input  logic                     clk,

    input  logic                     we_a_i,
    input  logic [$clog2(DEPTH)-1:0] addr_a_i,
    input  logic [DATA_WIDTH-1:0]    wdata_a_i,
    output logic [DATA_WIDTH-1:0]    rdata_a_o,

    input  logic                     we_b_i,
    input  logic [$clog2(DEPTH)-1:0] addr_b_i,
    input  logic [DATA_WIDTH-1:0]    wdata_b_i,
    output logic [DATA_WIDTH-1:0]    rdata_b_o
);

    logic [DATA_WIDTH-1:0] mem [DEPTH] = '{default: '0};

    // Read first on both sides
    always_ff @(posedge clk) begin
        rdata_a_o <= mem[addr_a_i];
        rdata_b_o <= mem[addr_b_i];
        if (we_a_i) begin
            mem[addr_a_i] <= wdata_a_i;
        end
        if (we_b_i) begin
            mem[addr_b_i] <= wdata_b_i;
        end
    end

endmodule

// ==== icache/icache.sv ====
module icache
    import icache_pkg::*;
#(
    parameter int NSET = 64,
    parameter int NWAY = 2
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  rreq_1_i,
    input  logic [ADDR_WIDTH-1:0] raddr_1_i,
    output logic                  rvalid_1_o,
    output logic [LINE_WIDTH-1:0] rdata_1_o,

    input  logic                  rreq_2_i,
    input  logic [ADDR_WIDTH-1:0] raddr_2_i,
    output logic                  rvalid_2_o,
    output logic [LINE_WIDTH-1:0] rdata_2_o,

    input  tlb_result_t           tlb_i,
    input  tlb_req_t              tlb_req_i,

    output refill_req_t           refill_req_o,
    input  refill_resp_t          refill_resp_i
);

    localparam int OFF_BITS = $clog2(LINE_WIDTH / 8);
    localparam int IDX_W    = $clog2(NSET);
    localparam int WAY_BITS = $clog2(NWAY);

    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] ppn;
    } tag_entry_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ_1,
        S_WAIT_1,
        S_REQ_2,
        S_WAIT_2
    } state_t;

    // Index 0 is port 1, index 1 is port 2
    logic [1:0]                           rreq;
    logic [1:0][ADDR_WIDTH-1:0]           raddr;
    logic [1:0]                           rvalid;
    logic [1:0][LINE_WIDTH-1:0]           rdata;

    logic [1:0]                           p1_rreq;
    logic [1:0]                           p1_trans_en;
    logic [1:0][ADDR_WIDTH-1:0]           p1_raddr;

    logic [1:0][IDX_W-1:0]                ram_idx;
    logic [NWAY-1:0][1:0]                 ram_we;
    tag_entry_t [1:0]                     tag_wd;
    tag_entry_t [NWAY-1:0][1:0]           tag_rd;
    logic [NWAY-1:0][1:0][LINE_WIDTH-1:0] data_rd;

    logic [1:0]                           hit;
    logic [1:0][LINE_WIDTH-1:0]           hit_line;
    logic [1:0]                           fault;
    logic [1:0]                           done_hit;
    logic [1:0]                           miss_pulse;
    logic [1:0]                           miss_r;
    logic [1:0]                           fill_r;
    logic [1:0]                           use_held;
    logic [1:0]                           fill_wr;
    logic [1:0][TAG_WIDTH-1:0]            ppn_r;
    logic [1:0][TAG_WIDTH-1:0]            lk_ppn;

    state_t                               state;
    state_t                               next_state;
    logic                                 serve;
    logic [2:0]                           lfsr;
    logic [WAY_BITS-1:0]                  victim;

    assign rreq       = {rreq_2_i, rreq_1_i};
    assign raddr      = {raddr_2_i, raddr_1_i};
    assign rvalid_1_o = rvalid[0];
    assign rvalid_2_o = rvalid[1];
    assign rdata_1_o  = rdata[0];
    assign rdata_2_o  = rdata[1];

    //////////////////////////////////////////////////
    // RAM addressing in the request cycle
    //////////////////////////////////////////////////

    // In-flight requests keep re-reading their own set
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (p1_rreq[p]) begin
                ram_idx[p] = p1_raddr[p][OFF_BITS +: IDX_W];
            end else begin
                ram_idx[p] = raddr[p][OFF_BITS +: IDX_W];
            end
            tag_wd[p] = '{valid: 1'b1, ppn: ppn_r[p]};
        end
    end

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        assign ram_we[w][0] = fill_wr[0] && (victim == WAY_BITS'(w));
        assign ram_we[w][1] = fill_wr[1] && (victim == WAY_BITS'(w));

        dp_bram #(
            .DATA_WIDTH(TAG_WIDTH + 1),
            .DEPTH     (NSET)
        ) u_tag (
            .clk      (clk),
            .we_a_i   (ram_we[w][0]),
            .addr_a_i (ram_idx[0]),
            .wdata_a_i(tag_wd[0]),
            .rdata_a_o(tag_rd[w][0]),
            .we_b_i   (ram_we[w][1]),
            .addr_b_i (ram_idx[1]),
            .wdata_b_i(tag_wd[1]),
            .rdata_b_o(tag_rd[w][1])
        );

        dp_bram #(
            .DATA_WIDTH(LINE_WIDTH),
            .DEPTH     (NSET)
        ) u_data (
            .clk      (clk),
            .we_a_i   (ram_we[w][0]),
            .addr_a_i (ram_idx[0]),
            .wdata_a_i(refill_resp_i.data),
            .rdata_a_o(data_rd[w][0]),
            .we_b_i   (ram_we[w][1]),
            .addr_b_i (ram_idx[1]),
            .wdata_b_i(refill_resp_i.data),
            .rdata_b_o(data_rd[w][1])
        );
    end

    //////////////////////////////////////////////////
    // Tag compare and line select in P1
    //////////////////////////////////////////////////

    // The request still held in the rvalid cycle is not a new one
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (rst) begin
                p1_rreq[p] <= 1'b0;
            end else if (rvalid[p]) begin
                p1_rreq[p] <= 1'b0;
            end else if (!p1_rreq[p]) begin
                p1_rreq[p] <= rreq[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (!p1_rreq[p]) begin
                p1_raddr[p]    <= raddr[p];
                p1_trans_en[p] <= tlb_req_i.trans_en;
            end
            if (miss_pulse[p]) begin
                ppn_r[p] <= tlb_i.ppn;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            // Live TLB answer only on the first lookup cycle
            use_held[p] = miss_r[p] | fill_r[p];
            lk_ppn[p]   = use_held[p] ? ppn_r[p] : tlb_i.ppn;

            hit[p]      = 1'b0;
            hit_line[p] = '0;
            for (int w = 0; w < NWAY; w++) begin
                if (tag_rd[w][p].valid && tag_rd[w][p].ppn == lk_ppn[p]) begin
                    hit[p]      = 1'b1;
                    hit_line[p] = data_rd[w][p];
                end
            end

            fault[p]      = p1_rreq[p] & ~use_held[p] & p1_trans_en[p] & ~tlb_i.found;
            done_hit[p]   = p1_rreq[p] & ~miss_r[p] & ~fault[p] & hit[p];
            miss_pulse[p] = p1_rreq[p] & ~use_held[p] & ~fault[p] & ~hit[p];
            rvalid[p]     = fault[p] | done_hit[p];
            rdata[p]      = done_hit[p] ? hit_line[p] : '0;
        end
    end

    //////////////////////////////////////////////////
    // Refill
    //////////////////////////////////////////////////

    assign fill_wr[0] = (state == S_WAIT_1) && refill_resp_i.rvalid;
    assign fill_wr[1] = (state == S_WAIT_2) && refill_resp_i.rvalid;

    // fill_r covers the cycle where the RAM still returns the old line
    always_ff @(posedge clk) begin
        if (rst) begin
            miss_r <= '0;
            fill_r <= '0;
        end else begin
            miss_r <= (miss_r | miss_pulse) & ~fill_wr;
            fill_r <= (fill_r | fill_wr) & ~rvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (miss_r[0]) begin
                    next_state = S_REQ_1;
                end else if (miss_r[1]) begin
                    next_state = S_REQ_2;
                end
            end
            S_REQ_1:  if (refill_resp_i.rdy) next_state = S_WAIT_1;
            S_WAIT_1: if (refill_resp_i.rvalid) next_state = S_IDLE;
            S_REQ_2:  if (refill_resp_i.rdy) next_state = S_WAIT_2;
            S_WAIT_2: if (refill_resp_i.rvalid) next_state = S_IDLE;
            default:  next_state = S_IDLE;
        endcase
    end

    assign serve = (state == S_REQ_2) || (state == S_WAIT_2);

    always_comb begin
        refill_req_o.req  = (state == S_REQ_1) || (state == S_REQ_2) ||
                            (((state == S_WAIT_1) || (state == S_WAIT_2)) &&
                             !refill_resp_i.rvalid);
        refill_req_o.addr = {ppn_r[serve], p1_raddr[serve][PAGE_OFFSET_BITS-1:OFF_BITS],
                             {OFF_BITS{1'b0}}};
    end

    // Free running LFSR on x^3 + x^2 + 1
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 3'b001;
        end else begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    assign victim = lfsr[WAY_BITS-1:0];

endmodule

// ==== icache/icache_refill_wb.sv ====
module icache_refill_wb
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  refill_req_t  refill_req_i,
    output refill_resp_t refill_resp_o,

    output wb_m2s_t      wb_o,
    input  wb_s2m_t      wb_i
);

    localparam int BEATS = LINE_WIDTH / WB_DATA_WIDTH;
    localparam int CNT_W = $clog2(BEATS);
    localparam int STEP  = WB_DATA_WIDTH / 8;

    typedef enum logic [1:0] {
        B_IDLE,
        B_BUSY,
        B_DONE
    } bstate_t;

    bstate_t               state;
    logic [CNT_W-1:0]      beat;
    logic [ADDR_WIDTH-1:0] adr_r;
    logic [LINE_WIDTH-1:0] line_r;
    logic                  accept;
    logic                  beat_ack;

    assign accept   = (state == B_IDLE) && refill_req_i.req;
    assign beat_ack = (state == B_BUSY) && wb_i.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= B_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                B_IDLE: begin
                    if (accept) begin
                        state <= B_BUSY;
                        beat  <= '0;
                    end
                end
                B_BUSY: begin
                    if (wb_i.ack) begin
                        beat <= beat + CNT_W'(1);
                        if (beat == CNT_W'(BEATS - 1)) begin
                            state <= B_DONE;
                        end
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    // Words shift in from the top, so the first beat ends up lowest
    always_ff @(posedge clk) begin
        if (accept) begin
            adr_r <= refill_req_i.addr;
        end else if (beat_ack) begin
            adr_r  <= adr_r + ADDR_WIDTH'(STEP);
            line_r <= {wb_i.dat, line_r[LINE_WIDTH-1:WB_DATA_WIDTH]};
        end
    end

    always_comb begin
        wb_o.cyc             = (state == B_BUSY);
        wb_o.stb             = (state == B_BUSY);
        wb_o.we              = 1'b0;
        wb_o.adr             = adr_r;
        wb_o.sel             = '1;
        refill_resp_o.rdy    = accept;
        refill_resp_o.rvalid = (state == B_DONE);
        refill_resp_o.data   = line_r;
    end

endmodule

// ==== hdl/icache_top.sv ====
module icache_top
    import icache_pkg::*;
#(
    parameter int NSET = 64,
    parameter int NWAY = 2
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  rreq_1_i,
    input  logic [ADDR_WIDTH-1:0] raddr_1_i,
    output logic                  rvalid_1_o,
    output logic [LINE_WIDTH-1:0] rdata_1_o,

    input  logic                  rreq_2_i,
    input  logic [ADDR_WIDTH-1:0] raddr_2_i,
    output logic                  rvalid_2_o,
    output logic [LINE_WIDTH-1:0] rdata_2_o,

    input  tlb_result_t           tlb_i,
    input  tlb_req_t              tlb_req_i,

    output wb_m2s_t               wb_o,
    input  wb_s2m_t               wb_i
);

    refill_req_t  refill_req;
    refill_resp_t refill_resp;

    icache #(
        .NSET(NSET),
        .NWAY(NWAY)
    ) u_icache (
        .clk          (clk),
        .rst          (rst),
        .rreq_1_i     (rreq_1_i),
        .raddr_1_i    (raddr_1_i),
        .rvalid_1_o   (rvalid_1_o),
        .rdata_1_o    (rdata_1_o),
        .rreq_2_i     (rreq_2_i),
        .raddr_2_i    (raddr_2_i),
        .rvalid_2_o   (rvalid_2_o),
        .rdata_2_o    (rdata_2_o),
        .tlb_i        (tlb_i),
        .tlb_req_i    (tlb_req_i),
        .refill_req_o (refill_req),
        .refill_resp_i(refill_resp)
    );

    icache_refill_wb u_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_req_i (refill_req),
        .refill_resp_o(refill_resp),
        .wb_o         (wb_o),
        .wb_i         (wb_i)
    );

endmodule

// ==== verif/wb_mem_model.sv ====
module wb_mem_model
    import icache_pkg::*;
#(
    parameter int SEED = 1
) (
    input  logic    clk,
    input  logic    rst,
    input  wb_m2s_t wb_i,
    output wb_s2m_t wb_o
);
    timeunit 1ns;
    timeprecision 100ps;

    integer                   seed = SEED;
    int                       wait_left = 0;
    logic                     armed = 1'b0;
    logic                     ack_r = 1'b0;
    logic [WB_DATA_WIDTH-1:0] dat_r = '0;

    // Each beat draws 0 to 3 wait states before the ack
    always @(posedge clk) begin
        if (rst) begin
            ack_r     <= 1'b0;
            armed     <= 1'b0;
            wait_left <= 0;
        end else if (ack_r) begin
            ack_r <= 1'b0;
        end else if (wb_i.cyc && wb_i.stb) begin
            if (!armed) begin
                wait_left <= $random(seed) & 3;
                armed     <= 1'b1;
            end else if (wait_left == 0) begin
                ack_r <= 1'b1;
                // Word address times the golden ratio constant
                dat_r <= (wb_i.adr >> 2) * 32'h9E3779B1;
                armed <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always_comb begin
        wb_o.ack = ack_r;
        wb_o.dat = dat_r;
    end

endmodule

// ==== verif/icache_assert.sv ====
module icache_assert
    import icache_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input wb_m2s_t wb_m_i,
    input wb_s2m_t wb_s_i,
    input logic    rvalid_1_i,
    input logic    rvalid_2_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    stb_within_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_m_i.stb |-> wb_m_i.cyc)
        else begin
            fail_count++;
            $error("wishbone stb is high while cyc is low");
        end

    no_write: assert property (@(posedge clk) disable iff (rst) !wb_m_i.we)
        else begin
            fail_count++;
            $error("wishbone we is high on a read-only bus");
        end

    // Classic bus holds the address until the slave acks
    adr_held: assert property (@(posedge clk) disable iff (rst)
        (wb_m_i.stb && !wb_s_i.ack) |=> $stable(wb_m_i.adr))
        else begin
            fail_count++;
            $error("wishbone adr changed while waiting for ack");
        end

    rvalid_low_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!rvalid_1_i && !rvalid_2_i))
        else begin
            fail_count++;
            $error("rvalid is high in the first cycle after reset");
        end

endmodule

// ==== verif/icache_tb.sv ====
module icache_tb
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NSET         = 64;
    localparam int NWAY         = 2;
    localparam int PERIOD       = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 39654;
    localparam int FETCH_BUDGET = 400;
    localparam int NUM_FETCHES  = 6 + 2 * (NWAY + 2);

    localparam logic [TAG_WIDTH-1:0]  PPN_XOR = 20'h000A5;
    localparam logic [ADDR_WIDTH-1:0] VA_A    = 32'h0001_2340;
    localparam logic [ADDR_WIDTH-1:0] VA_B1   = 32'h0003_4100;
    localparam logic [ADDR_WIDTH-1:0] VA_B2   = 32'h0003_4280;
    localparam logic [ADDR_WIDTH-1:0] VA_C    = 32'h0005_6780;

    logic                  clk;
    logic                  rst;
    logic                  rreq_1;
    logic [ADDR_WIDTH-1:0] raddr_1;
    logic                  rvalid_1;
    logic [LINE_WIDTH-1:0] rdata_1;
    logic                  rreq_2;
    logic [ADDR_WIDTH-1:0] raddr_2;
    logic                  rvalid_2;
    logic [LINE_WIDTH-1:0] rdata_2;
    tlb_result_t           tlb_res;
    tlb_req_t              tlb_req;
    logic                  tlb_found;
    wb_m2s_t               wb_m;
    wb_s2m_t               wb_s;

    int                    errors;
    logic [LINE_WIDTH-1:0] got_1;
    logic [LINE_WIDTH-1:0] got_2;
    int                    lat_1;
    int                    lat_2;
    int                    wb_cyc;
    int                    wb_ack;

    icache_top #(
        .NSET(NSET),
        .NWAY(NWAY)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .rreq_1_i  (rreq_1),
        .raddr_1_i (raddr_1),
        .rvalid_1_o(rvalid_1),
        .rdata_1_o (rdata_1),
        .rreq_2_i  (rreq_2),
        .raddr_2_i (raddr_2),
        .rvalid_2_o(rvalid_2),
        .rdata_2_o (rdata_2),
        .tlb_i     (tlb_res),
        .tlb_req_i (tlb_req),
        .wb_o      (wb_m),
        .wb_i      (wb_s)
    );

    wb_mem_model #(
        .SEED(SEED)
    ) u_mem (
        .clk (clk),
        .rst (rst),
        .wb_i(wb_m),
        .wb_o(wb_s)
    );

    bind icache_top icache_assert u_assert (
        .clk       (clk),
        .rst       (rst),
        .wb_m_i    (wb_o),
        .wb_s_i    (wb_i),
        .rvalid_1_i(rvalid_1_o),
        .rvalid_2_i(rvalid_2_o)
    );

    // TLB stub with a fixed page mapping
    always_comb begin
        tlb_res.found = tlb_found;
        tlb_res.ppn   = tlb_req.vpn ^ PPN_XOR;
    end

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES + FETCH_BUDGET * NUM_FETCHES) @(posedge clk);
        $display("timeout: the fetches did not complete in the allowed time");
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [ADDR_WIDTH-1:0] phys_line(input logic [ADDR_WIDTH-1:0] va);
        return {va[ADDR_WIDTH-1:PAGE_OFFSET_BITS] ^ PPN_XOR, va[PAGE_OFFSET_BITS-1:4], 4'h0};
    endfunction

    function automatic logic [WB_DATA_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] pa);
        return (pa >> 2) * 32'h9E3779B1;
    endfunction

    // First word of the line sits in the lowest bits
    function automatic logic [LINE_WIDTH-1:0] expected_line(input logic [ADDR_WIDTH-1:0] va);
        logic [ADDR_WIDTH-1:0] base;
        logic [LINE_WIDTH-1:0] line;
        base = phys_line(va);
        for (int i = 0; i < 4; i++) begin
            line[32*i +: 32] = mem_word(base + 32'(4 * i));
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [LINE_WIDTH-1:0] got,
                               input logic [LINE_WIDTH-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // Driver
    //////////////////////////////////////////////////

    task automatic fetch(input logic en_1, input logic en_2,
                         input logic [ADDR_WIDTH-1:0] va_1, input logic [ADDR_WIDTH-1:0] va_2);
        logic done_1;
        logic done_2;
        logic cyc_q;
        int   t;
        done_1 = !en_1;
        done_2 = !en_2;
        cyc_q  = 1'b0;
        t      = 0;
        got_1  = '0;
        got_2  = '0;
        lat_1  = 0;
        lat_2  = 0;
        wb_cyc = 0;
        wb_ack = 0;
        @(posedge clk);
        #DRIVE_DELAY;
        rreq_1      = en_1;
        raddr_1     = va_1;
        rreq_2      = en_2;
        raddr_2     = va_2;
        tlb_req.vpn = en_1 ? va_1[ADDR_WIDTH-1:PAGE_OFFSET_BITS] :
                             va_2[ADDR_WIDTH-1:PAGE_OFFSET_BITS];
        while (!(done_1 && done_2)) begin
            @(negedge clk);
            if (wb_m.cyc && !cyc_q) begin
                wb_cyc++;
            end
            cyc_q = wb_m.cyc;
            if (wb_s.ack) begin
                wb_ack++;
            end
            if (!done_1 && rvalid_1) begin
                done_1 = 1'b1;
                got_1  = rdata_1;
                lat_1  = t;
            end
            if (!done_2 && rvalid_2) begin
                done_2 = 1'b1;
                got_2  = rdata_2;
                lat_2  = t;
            end
            t++;
            @(posedge clk);
            #DRIVE_DELAY;
            if (done_1) begin
                rreq_1 = 1'b0;
            end
            if (done_2) begin
                rreq_2 = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic cold_miss();
        fetch(1'b1, 1'b0, VA_A, '0);
        check_value("rdata_1_o", got_1, expected_line(VA_A));
        check_value("wb_o.cyc rises", 128'(wb_cyc), 128'd1);
        check_value("wb_i.ack count", 128'(wb_ack), 128'd4);
    endtask

    task automatic hit_after_fill();
        fetch(1'b1, 1'b0, VA_A, '0);
        check_value("rdata_1_o", got_1, expected_line(VA_A));
        check_value("rvalid_1_o latency", 128'(lat_1), 128'd1);
        check_value("wb_o.cyc rises", 128'(wb_cyc), 128'd0);
        fetch(1'b0, 1'b1, '0, VA_A);
        check_value("rdata_2_o", got_2, expected_line(VA_A));
        check_value("rvalid_2_o latency", 128'(lat_2), 128'd1);
        check_value("wb_o.cyc rises", 128'(wb_cyc), 128'd0);
    endtask

    // Same page on both ports, since the TLB answers once per cycle
    task automatic dual_miss();
        fetch(1'b1, 1'b1, VA_B1, VA_B2);
        check_value("rdata_1_o", got_1, expected_line(VA_B1));
        check_value("rdata_2_o", got_2, expected_line(VA_B2));
        check_value("rvalid_1_o not after rvalid_2_o", 128'(lat_1 <= lat_2), 128'd1);
        check_value("wb_o.cyc rises", 128'(wb_cyc), 128'd2);
    endtask

    task automatic tlb_fault();
        tlb_found        = 1'b0;
        tlb_req.trans_en = 1'b1;
        fetch(1'b1, 1'b0, VA_C, '0);
        check_value("rdata_1_o", got_1, '0);
        check_value("rvalid_1_o latency", 128'(lat_1), 128'd1);
        check_value("wb_o.cyc rises", 128'(wb_cyc), 128'd0);
        tlb_req.trans_en = 1'b0;
        fetch(1'b1, 1'b0, VA_C, '0);
        check_value("rdata_1_o", got_1, expected_line(VA_C));
        check_value("wb_o.cyc rises", 128'(wb_cyc), 128'd1);
        tlb_found        = 1'b1;
        tlb_req.trans_en = 1'b1;
    endtask

    // More pages than ways share one set and are read forward then backward
    task automatic conflict_set();
        logic [ADDR_WIDTH-1:0] va;
        int                    idx;
        for (int k = 0; k < 2 * (NWAY + 2); k++) begin
            idx = (k < NWAY + 2) ? k : 2 * (NWAY + 2) - 1 - k;
            va  = {TAG_WIDTH'(32'h100 + idx), 12'h3C0};
            fetch(1'b1, 1'b0, va, '0);
            check_value("rdata_1_o", got_1, expected_line(va));
        end
    endtask

    initial begin
        errors           = 0;
        rst              = 1'b1;
        rreq_1           = 1'b0;
        raddr_1          = '0;
        rreq_2           = 1'b0;
        raddr_2          = '0;
        tlb_req.trans_en = 1'b1;
        tlb_req.vpn      = '0;
        tlb_found        = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        cold_miss();
        hit_after_fill();
        dual_miss();
        tlb_fault();
        conflict_set();

        $display("check errors: %0d, assertion failures: %0d", errors,
                 dut.u_assert.fail_count);
        if (errors == 0 && dut.u_assert.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/icache_pkg.sv
hdl/dp_bram.sv
icache/icache.sv
icache/icache_refill_wb.sv
hdl/icache_top.sv
verif/wb_mem_model.sv
verif/icache_assert.sv
verif/icache_tb.sv

// ==== Makefile ====
# Verilator build and run for the icache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= NO ERRORS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
